// ==== verilog.f ====
+incdir+source
source/idu_pkg.sv
source/idu_inst_class.sv
source/idu_imm_gen.sv
source/idu_ctrl_enc.sv
source/idu.sv
verif/tb_clock.sv
verif/tb_idu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_idu -f verilog.f

# Simulator exits nonzero on $fatal
sim_out=$(./obj_dir/Vtb_idu 2>&1) || true
echo "$sim_out"

if grep -q "^Result: PASSED$" <<< "$sim_out"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// ==== verif/tb_idu.sv ====
`include "idu_defines.svh"

module tb_idu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DIR       = 96;   // 8 funct3 groups of 11 plus 8 fixed words
    localparam int N_RAND      = 300;
    localparam int STIM_CYCLES = N_DIR + N_RAND + 3;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

    logic                 clk;
    logic                 rst;
    logic                 inst_valid;
    logic [`IDU_XLEN-1:0] inst;
    logic                 out_valid;
    idu_pkg::dec_bundle_t dec;

    idu_pkg::dec_bundle_t exp_q[$];  // Words sent but not yet on dec
    idu_pkg::dec_bundle_t exp_cur;   // What dec must show this cycle
    logic                 exp_valid;
    integer               seed;
    int                   cycle_count;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    idu u_dut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .dec        (dec)
    );

    // Expected bundle for one word from the RV32I encoding rules
    function automatic idu_pkg::dec_bundle_t expect_decode(input logic [31:0] w);
        idu_pkg::dec_bundle_t d;
        idu_pkg::alu_sel_e    alu;
        idu_pkg::pc_sel_e     pc;
        logic [6:0]           f7;
        logic [2:0]           f3;
        logic [31:0]          imm_i;
        logic [31:0]          imm;
        logic                 known;
        logic                 writes_rd;
        logic                 reads_rs1;
        logic                 writes_csr;
        logic                 is_ecall;
        f7         = w[31:25];
        f3         = w[14:12];
        imm_i      = {{20{w[31]}}, w[31:20]};
        imm        = imm_i;
        alu        = idu_pkg::ALU_NONE;
        pc         = idu_pkg::PC_SEQ;
        known      = 1'b1;
        writes_rd  = 1'b0;
        reads_rs1  = 1'b0;
        writes_csr = 1'b0;
        is_ecall   = 1'b0;
        case (w[6:0])
            `IDU_OPC_OP: begin
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
                case ({f7, f3})
                    {`IDU_F7_BASE, 3'b000}: alu = idu_pkg::ALU_ADD;
                    {`IDU_F7_BASE, 3'b001}: alu = idu_pkg::ALU_SLL;
                    {`IDU_F7_BASE, 3'b010}: alu = idu_pkg::ALU_SLT;
                    {`IDU_F7_BASE, 3'b011}: alu = idu_pkg::ALU_SLTU;
                    {`IDU_F7_BASE, 3'b100}: alu = idu_pkg::ALU_XOR;
                    {`IDU_F7_BASE, 3'b101}: alu = idu_pkg::ALU_SRL;
                    {`IDU_F7_BASE, 3'b110}: alu = idu_pkg::ALU_OR;
                    {`IDU_F7_BASE, 3'b111}: alu = idu_pkg::ALU_AND;
                    {`IDU_F7_ALT, 3'b000}:  alu = idu_pkg::ALU_SUB;
                    {`IDU_F7_ALT, 3'b101}:  alu = idu_pkg::ALU_SRA;
                    default:                known = 1'b0;
                endcase
            end
            `IDU_OPC_OP_IMM: begin
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
                case (f3)
                    3'b000: alu = idu_pkg::ALU_NONE;  // addi shares the illegal select
                    3'b010: alu = idu_pkg::ALU_SLTI;
                    3'b011: alu = idu_pkg::ALU_SLTIU;
                    3'b100: alu = idu_pkg::ALU_XORI;
                    3'b110: alu = idu_pkg::ALU_ORI;
                    3'b111: alu = idu_pkg::ALU_ANDI;
                    3'b001: begin
                        alu   = idu_pkg::ALU_SLLI;
                        known = (f7 == `IDU_F7_BASE);
                    end
                    default: begin
                        alu   = (f7 == `IDU_F7_ALT) ? idu_pkg::ALU_SRAI : idu_pkg::ALU_SRLI;
                        known = (f7 == `IDU_F7_BASE) || (f7 == `IDU_F7_ALT);
                    end
                endcase
            end
            `IDU_OPC_LOAD: begin
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
                case (f3)
                    3'b000:  alu = idu_pkg::ALU_LB;
                    3'b001:  alu = idu_pkg::ALU_LH;
                    3'b010:  alu = idu_pkg::ALU_LW;
                    3'b100:  alu = idu_pkg::ALU_LBU;
                    3'b101:  alu = idu_pkg::ALU_LHU;
                    default: known = 1'b0;
                endcase
            end
            `IDU_OPC_STORE: begin
                reads_rs1 = 1'b1;
                imm       = {{20{w[31]}}, w[31:25], w[11:7]};
                case (f3)
                    3'b000:  alu = idu_pkg::ALU_SB;
                    3'b001:  alu = idu_pkg::ALU_SH;
                    3'b010:  alu = idu_pkg::ALU_SW;
                    default: known = 1'b0;
                endcase
            end
            `IDU_OPC_BRANCH: begin
                reads_rs1 = 1'b1;
                pc        = idu_pkg::PC_BRANCH;
                imm       = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'b000:  alu = idu_pkg::ALU_BEQ;
                    3'b001:  alu = idu_pkg::ALU_BNE;
                    3'b100:  alu = idu_pkg::ALU_BLT;
                    3'b101:  alu = idu_pkg::ALU_BGE;
                    3'b110:  alu = idu_pkg::ALU_BLTU;
                    3'b111:  alu = idu_pkg::ALU_BGEU;
                    default: known = 1'b0;
                endcase
            end
            `IDU_OPC_JAL: begin
                alu       = idu_pkg::ALU_JUMP;
                writes_rd = 1'b1;
                pc        = idu_pkg::PC_JAL;
                imm       = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            `IDU_OPC_JALR: begin
                alu       = idu_pkg::ALU_JUMP;
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
                pc        = idu_pkg::PC_JALR;
                known     = (f3 == 3'b000);
            end
            `IDU_OPC_LUI, `IDU_OPC_AUIPC: begin
                alu       = (w[5]) ? idu_pkg::ALU_LUI : idu_pkg::ALU_AUIPC;
                writes_rd = 1'b1;
                imm       = {w[31:12], 12'h000};
            end
            `IDU_OPC_SYSTEM: begin
                case (f3)
                    3'b000: begin
                        pc       = idu_pkg::PC_TRAP;
                        imm      = '0;
                        is_ecall = (w[31:20] == 12'h000);
                        known    = is_ecall || (f7 == `IDU_F7_MRET);  // ebreak fails both
                    end
                    3'b001, 3'b010: begin
                        alu        = (f3 == 3'b001) ? idu_pkg::ALU_CSRRW : idu_pkg::ALU_CSRRS;
                        writes_rd  = 1'b1;
                        reads_rs1  = 1'b1;
                        writes_csr = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        d     = '0;
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.imm = imm_i;  // Unmatched words still carry the I immediate
        if (known) begin
            d.alu_sel = alu;
            d.pc_sel  = pc;
            d.wen     = writes_rd;
            d.rs_read = reads_rs1;
            d.csr_wen = writes_csr;
            d.ecall   = is_ecall;
            d.imm     = imm;
        end
        return d;
    endfunction

    function automatic logic [31:0] rand_opc(input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:7], opc};
    endfunction

    function automatic logic [31:0] rand_fields(input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] r;
        r = rand_opc(opc);
        return {r[31:15], f3, r[11:0]};
    endfunction

    function automatic logic [31:0] with_f7(input logic [6:0] f7, input logic [31:0] w);
        return {f7, w[24:0]};
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] k);
        case (k)
            4'd0:    return `IDU_OPC_OP;
            4'd1:    return `IDU_OPC_OP_IMM;
            4'd2:    return `IDU_OPC_LOAD;
            4'd3:    return `IDU_OPC_STORE;
            4'd4:    return `IDU_OPC_BRANCH;
            4'd5:    return `IDU_OPC_JAL;
            4'd6:    return `IDU_OPC_JALR;
            4'd7:    return `IDU_OPC_LUI;
            4'd8:    return `IDU_OPC_AUIPC;
            4'd9:    return `IDU_OPC_SYSTEM;
            default: return 7'b0001011;  // Custom-0 is never decoded
        endcase
    endfunction

    task automatic stop_with_error(input string what);
        $display("Error: %0d ns: %s", $time, what);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // One word per falling edge while expectations follow the DUT register
    task automatic send_word(input logic [31:0] w, input logic v);
        @(negedge clk);
        exp_valid = inst_valid;  // Strobe taken at the last rising edge
        if (inst_valid) exp_cur = exp_q.pop_front();
        inst       = w;
        inst_valid = v;
        if (v) exp_q.push_back(expect_decode(w));
    endtask

    assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
        else stop_with_error($sformatf("out_valid is %0b, expected %0b",
                                       $sampled(out_valid), exp_valid));
    assert property (@(posedge clk) disable iff (rst) dec.alu_sel == exp_cur.alu_sel)
        else stop_with_error($sformatf("dec.alu_sel is %0d, expected %0d",
                                       $sampled(dec.alu_sel), exp_cur.alu_sel));
    assert property (@(posedge clk) disable iff (rst) dec.pc_sel == exp_cur.pc_sel)
        else stop_with_error($sformatf("dec.pc_sel is %0d, expected %0d",
                                       $sampled(dec.pc_sel), exp_cur.pc_sel));
    assert property (@(posedge clk) disable iff (rst) dec.wen == exp_cur.wen)
        else stop_with_error($sformatf("dec.wen is %0b, expected %0b",
                                       $sampled(dec.wen), exp_cur.wen));
    assert property (@(posedge clk) disable iff (rst) dec.rs_read == exp_cur.rs_read)
        else stop_with_error($sformatf("dec.rs_read is %0b, expected %0b",
                                       $sampled(dec.rs_read), exp_cur.rs_read));
    assert property (@(posedge clk) disable iff (rst) dec.csr_wen == exp_cur.csr_wen)
        else stop_with_error($sformatf("dec.csr_wen is %0b, expected %0b",
                                       $sampled(dec.csr_wen), exp_cur.csr_wen));
    assert property (@(posedge clk) disable iff (rst) dec.ecall == exp_cur.ecall)
        else stop_with_error($sformatf("dec.ecall is %0b, expected %0b",
                                       $sampled(dec.ecall), exp_cur.ecall));
    assert property (@(posedge clk) disable iff (rst) dec.rd == exp_cur.rd)
        else stop_with_error($sformatf("dec.rd is %0d, expected %0d",
                                       $sampled(dec.rd), exp_cur.rd));
    assert property (@(posedge clk) disable iff (rst) dec.rs1 == exp_cur.rs1)
        else stop_with_error($sformatf("dec.rs1 is %0d, expected %0d",
                                       $sampled(dec.rs1), exp_cur.rs1));
    assert property (@(posedge clk) disable iff (rst) dec.rs2 == exp_cur.rs2)
        else stop_with_error($sformatf("dec.rs2 is %0d, expected %0d",
                                       $sampled(dec.rs2), exp_cur.rs2));
    assert property (@(posedge clk) disable iff (rst) dec.imm == exp_cur.imm)
        else stop_with_error($sformatf("dec.imm is %h, expected %h",
                                       $sampled(dec.imm), exp_cur.imm));

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_with_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] pick;
        logic [2:0]  f3;
        seed        = 32'hfedd;
        inst_valid  = 1'b0;
        inst        = '0;
        exp_valid   = 1'b0;
        exp_cur     = '0;
        cycle_count = 0;
        @(negedge rst);

        // Every funct3 for each major opcode with an idle cycle closing each group
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            send_word(with_f7(`IDU_F7_BASE, rand_fields(f3, `IDU_OPC_OP)), 1'b1);
            send_word(with_f7(`IDU_F7_ALT, rand_fields(f3, `IDU_OPC_OP)), 1'b1);
            send_word(with_f7(7'b0000001, rand_fields(f3, `IDU_OPC_OP)), 1'b1);  // M ext
            send_word(with_f7(`IDU_F7_BASE, rand_fields(f3, `IDU_OPC_OP_IMM)), 1'b1);
            send_word(with_f7(`IDU_F7_ALT, rand_fields(f3, `IDU_OPC_OP_IMM)), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_LOAD), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_STORE), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_BRANCH), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_JALR), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_SYSTEM), 1'b1);
            send_word(rand_fields(f3, `IDU_OPC_OP), 1'b0);  // dec must hold
        end

        send_word(32'h0000_0073, 1'b1);  // ecall
        send_word(32'h0010_0073, 1'b1);  // ebreak
        send_word(32'h3020_0073, 1'b1);  // mret
        send_word(rand_opc(`IDU_OPC_JAL), 1'b1);
        send_word(rand_opc(`IDU_OPC_LUI), 1'b1);
        send_word(rand_opc(`IDU_OPC_AUIPC), 1'b1);
        send_word(rand_opc(7'b1111111), 1'b1);
        send_word(32'h0000_0000, 1'b1);

        for (int n = 0; n < N_RAND; n++) begin
            pick = $random(seed);
            w    = rand_opc(pick_opcode(pick[7:4]));
            if (pick[2:0] == 3'b000) begin
                w = $random(seed);  // Fully random word
            end else if (pick[8] && (w[6:0] == `IDU_OPC_OP || w[6:0] == `IDU_OPC_OP_IMM)) begin
                w = with_f7(pick[9] ? `IDU_F7_ALT : `IDU_F7_BASE, w);
            end
            send_word(w, pick[12:10] != 3'b000);  // Mostly back-to-back
        end

        // Drain the last result through the register and its check
        repeat (3) send_word('0, 1'b0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;  // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Three rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== source/idu.sv ====
`include "idu_defines.svh"

module idu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_valid,
    input  logic [`IDU_XLEN-1:0] inst,
    output logic                 out_valid,
    output idu_pkg::dec_bundle_t dec
);

    idu_pkg::inst_word_u  inst_w;
    idu_pkg::inst_id_e    inst_id;
    idu_pkg::imm_fmt_e    imm_fmt;
    idu_pkg::dec_bundle_t dec_next;  // Combinational decode of the current word

    assign inst_w = idu_pkg::inst_word_u'(inst);

    idu_inst_class u_inst_class (
        .inst    (inst_w),
        .inst_id (inst_id)
    );

    idu_ctrl_enc u_ctrl_enc (
        .inst_id (inst_id),
        .alu_sel (dec_next.alu_sel),
        .pc_sel  (dec_next.pc_sel),
        .imm_fmt (imm_fmt),
        .wen     (dec_next.wen),
        .rs_read (dec_next.rs_read),
        .csr_wen (dec_next.csr_wen),
        .ecall   (dec_next.ecall)
    );

    idu_imm_gen u_imm_gen (
        .inst    (inst_w),
        .imm_fmt (imm_fmt),
        .imm     (dec_next.imm)
    );

    // Index fields sit at the same place in every format
    assign dec_next.rd  = inst_w.r.rd;
    assign dec_next.rs1 = inst_w.r.rs1;
    assign dec_next.rs2 = inst_w.r.rs2;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            dec       <= '0;
        end else begin
            out_valid <= inst_valid;
            if (inst_valid) dec <= dec_next;  // Hold last result when idle
        end
    end

endmodule

// ==== source/idu_ctrl_enc.sv ====
module idu_ctrl_enc (
    input  idu_pkg::inst_id_e inst_id,
    output idu_pkg::alu_sel_e alu_sel,
    output idu_pkg::pc_sel_e  pc_sel,
    output idu_pkg::imm_fmt_e imm_fmt,
    output logic              wen,
    output logic              rs_read,
    output logic              csr_wen,
    output logic              ecall
);

    // ALU numbering, addi deliberately left at ALU_NONE
    always_comb begin
        case (inst_id)
            idu_pkg::INST_AUIPC: alu_sel = idu_pkg::ALU_AUIPC;
            idu_pkg::INST_LUI:   alu_sel = idu_pkg::ALU_LUI;
            idu_pkg::INST_JAL,
            idu_pkg::INST_JALR:  alu_sel = idu_pkg::ALU_JUMP;  // Both compute pc + 4
            idu_pkg::INST_BEQ:   alu_sel = idu_pkg::ALU_BEQ;
            idu_pkg::INST_SW:    alu_sel = idu_pkg::ALU_SW;
            idu_pkg::INST_LW:    alu_sel = idu_pkg::ALU_LW;
            idu_pkg::INST_SLTIU: alu_sel = idu_pkg::ALU_SLTIU;
            idu_pkg::INST_BNE:   alu_sel = idu_pkg::ALU_BNE;
            idu_pkg::INST_ADD:   alu_sel = idu_pkg::ALU_ADD;
            idu_pkg::INST_SUB:   alu_sel = idu_pkg::ALU_SUB;
            idu_pkg::INST_OR:    alu_sel = idu_pkg::ALU_OR;
            idu_pkg::INST_XOR:   alu_sel = idu_pkg::ALU_XOR;
            idu_pkg::INST_SLTU:  alu_sel = idu_pkg::ALU_SLTU;
            idu_pkg::INST_BGE:   alu_sel = idu_pkg::ALU_BGE;
            idu_pkg::INST_SLLI:  alu_sel = idu_pkg::ALU_SLLI;
            idu_pkg::INST_ANDI:  alu_sel = idu_pkg::ALU_ANDI;
            idu_pkg::INST_SRLI:  alu_sel = idu_pkg::ALU_SRLI;
            idu_pkg::INST_SLTI:  alu_sel = idu_pkg::ALU_SLTI;
            idu_pkg::INST_BLT:   alu_sel = idu_pkg::ALU_BLT;
            idu_pkg::INST_BLTU:  alu_sel = idu_pkg::ALU_BLTU;
            idu_pkg::INST_BGEU:  alu_sel = idu_pkg::ALU_BGEU;
            idu_pkg::INST_SLL:   alu_sel = idu_pkg::ALU_SLL;
            idu_pkg::INST_SLT:   alu_sel = idu_pkg::ALU_SLT;
            idu_pkg::INST_XORI:  alu_sel = idu_pkg::ALU_XORI;
            idu_pkg::INST_ORI:   alu_sel = idu_pkg::ALU_ORI;
            idu_pkg::INST_LBU:   alu_sel = idu_pkg::ALU_LBU;
            idu_pkg::INST_SRAI:  alu_sel = idu_pkg::ALU_SRAI;
            idu_pkg::INST_SB:    alu_sel = idu_pkg::ALU_SB;
            idu_pkg::INST_SH:    alu_sel = idu_pkg::ALU_SH;
            idu_pkg::INST_AND:   alu_sel = idu_pkg::ALU_AND;
            idu_pkg::INST_LB:    alu_sel = idu_pkg::ALU_LB;
            idu_pkg::INST_LH:    alu_sel = idu_pkg::ALU_LH;
            idu_pkg::INST_SRL:   alu_sel = idu_pkg::ALU_SRL;
            idu_pkg::INST_SRA:   alu_sel = idu_pkg::ALU_SRA;
            idu_pkg::INST_LHU:   alu_sel = idu_pkg::ALU_LHU;
            idu_pkg::INST_CSRRW: alu_sel = idu_pkg::ALU_CSRRW;
            idu_pkg::INST_CSRRS: alu_sel = idu_pkg::ALU_CSRRS;
            default:             alu_sel = idu_pkg::ALU_NONE;
        endcase
    end

    // Enables, PC source and immediate format by instruction group
    always_comb begin
        pc_sel  = idu_pkg::PC_SEQ;
        imm_fmt = idu_pkg::IMM_I;
        wen     = 1'b0;
        rs_read = 1'b0;
        csr_wen = 1'b0;
        ecall   = 1'b0;
        case (inst_id)
            idu_pkg::INST_ADD, idu_pkg::INST_SUB, idu_pkg::INST_SLL, idu_pkg::INST_SLT,
            idu_pkg::INST_SLTU, idu_pkg::INST_XOR, idu_pkg::INST_SRL, idu_pkg::INST_SRA,
            idu_pkg::INST_OR, idu_pkg::INST_AND,
            idu_pkg::INST_ADDI, idu_pkg::INST_SLTI, idu_pkg::INST_SLTIU, idu_pkg::INST_XORI,
            idu_pkg::INST_ORI, idu_pkg::INST_ANDI, idu_pkg::INST_SLLI, idu_pkg::INST_SRLI,
            idu_pkg::INST_SRAI,
            idu_pkg::INST_LB, idu_pkg::INST_LH, idu_pkg::INST_LW, idu_pkg::INST_LBU,
            idu_pkg::INST_LHU: begin
                wen     = 1'b1;
                rs_read = 1'b1;
            end
            idu_pkg::INST_SB, idu_pkg::INST_SH, idu_pkg::INST_SW: begin
                rs_read = 1'b1;
                imm_fmt = idu_pkg::IMM_S;
            end
            idu_pkg::INST_BEQ, idu_pkg::INST_BNE, idu_pkg::INST_BLT,
            idu_pkg::INST_BGE, idu_pkg::INST_BLTU, idu_pkg::INST_BGEU: begin
                rs_read = 1'b1;
                imm_fmt = idu_pkg::IMM_B;
                pc_sel  = idu_pkg::PC_BRANCH;
            end
            idu_pkg::INST_LUI, idu_pkg::INST_AUIPC: begin
                wen     = 1'b1;
                imm_fmt = idu_pkg::IMM_U;
            end
            idu_pkg::INST_JAL: begin
                wen     = 1'b1;
                imm_fmt = idu_pkg::IMM_J;
                pc_sel  = idu_pkg::PC_JAL;
            end
            idu_pkg::INST_JALR: begin
                wen     = 1'b1;
                rs_read = 1'b1;
                pc_sel  = idu_pkg::PC_JALR;
            end
            idu_pkg::INST_CSRRW, idu_pkg::INST_CSRRS: begin
                wen     = 1'b1;  // Old CSR value to rd
                rs_read = 1'b1;
                csr_wen = 1'b1;
            end
            idu_pkg::INST_ECALL: begin
                ecall   = 1'b1;
                imm_fmt = idu_pkg::IMM_ZERO;
                pc_sel  = idu_pkg::PC_TRAP;
            end
            idu_pkg::INST_MRET: begin
                imm_fmt = idu_pkg::IMM_ZERO;
                pc_sel  = idu_pkg::PC_TRAP;  // Return target comes from mepc
            end
            default: ;
        endcase
    end

endmodule

// ==== source/idu_imm_gen.sv ====
`include "idu_defines.svh"

module idu_imm_gen (
    input  idu_pkg::inst_word_u  inst,
    input  idu_pkg::imm_fmt_e    imm_fmt,
    output logic [`IDU_XLEN-1:0] imm
);

    logic sign;  // Always inst[31], whatever the format

    assign sign = inst.r.funct7[6];

    always_comb begin
        case (imm_fmt)
            idu_pkg::IMM_I: begin
                imm = {{(`IDU_XLEN-12){sign}}, inst.i.imm_11_0};
            end
            idu_pkg::IMM_S: begin
                imm = {{(`IDU_XLEN-12){sign}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            idu_pkg::IMM_B: begin
                // Halfword offset, bit 0 forced low
                imm = {{(`IDU_XLEN-12){sign}},
                       inst.b.imm_11,
                       inst.b.imm_10_5,
                       inst.b.imm_4_1,
                       1'b0};
            end
            idu_pkg::IMM_U: begin
                imm = {inst.u.imm_31_12, 12'h000};  // Upper 20 bits in place
            end
            idu_pkg::IMM_J: begin
                imm = {{(`IDU_XLEN-20){sign}},
                       inst.j.imm_19_12,
                       inst.j.imm_11,
                       inst.j.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = '0;  // IMM_ZERO for ecall and mret
            end
        endcase
    end

endmodule

// ==== source/idu_inst_class.sv ====
`include "idu_defines.svh"

module idu_inst_class (
    input  idu_pkg::inst_word_u inst,
    output idu_pkg::inst_id_e   inst_id
);

    logic [2:0] funct3;
    logic       f7_base;
    logic       f7_alt;
    logic       f7_mret;

    assign funct3  = inst.r.funct3;
    assign f7_base = (inst.r.funct7 == `IDU_F7_BASE);
    assign f7_alt  = (inst.r.funct7 == `IDU_F7_ALT);
    assign f7_mret = (inst.r.funct7 == `IDU_F7_MRET);

    always_comb begin
        inst_id = idu_pkg::INST_ILLEGAL;  // Anything unmatched
        case (inst.r.opcode)
            `IDU_OPC_OP: begin
                if (f7_base) begin
                    case (funct3)
                        3'b000:  inst_id = idu_pkg::INST_ADD;
                        3'b001:  inst_id = idu_pkg::INST_SLL;
                        3'b010:  inst_id = idu_pkg::INST_SLT;
                        3'b011:  inst_id = idu_pkg::INST_SLTU;
                        3'b100:  inst_id = idu_pkg::INST_XOR;
                        3'b101:  inst_id = idu_pkg::INST_SRL;
                        3'b110:  inst_id = idu_pkg::INST_OR;
                        default: inst_id = idu_pkg::INST_AND;
                    endcase
                end else if (f7_alt) begin
                    case (funct3)
                        3'b000:  inst_id = idu_pkg::INST_SUB;
                        3'b101:  inst_id = idu_pkg::INST_SRA;
                        default: ;
                    endcase
                end
            end
            `IDU_OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  inst_id = idu_pkg::INST_ADDI;
                    3'b010:  inst_id = idu_pkg::INST_SLTI;
                    3'b011:  inst_id = idu_pkg::INST_SLTIU;
                    3'b100:  inst_id = idu_pkg::INST_XORI;
                    3'b110:  inst_id = idu_pkg::INST_ORI;
                    3'b111:  inst_id = idu_pkg::INST_ANDI;
                    3'b001: begin
                        if (f7_base) inst_id = idu_pkg::INST_SLLI;
                    end
                    default: begin  // 3'b101, upper imm bits pick the shift
                        if (f7_base) begin
                            inst_id = idu_pkg::INST_SRLI;
                        end else if (f7_alt) begin
                            inst_id = idu_pkg::INST_SRAI;
                        end
                    end
                endcase
            end
            `IDU_OPC_LOAD: begin
                case (funct3)
                    3'b000:  inst_id = idu_pkg::INST_LB;
                    3'b001:  inst_id = idu_pkg::INST_LH;
                    3'b010:  inst_id = idu_pkg::INST_LW;
                    3'b100:  inst_id = idu_pkg::INST_LBU;
                    3'b101:  inst_id = idu_pkg::INST_LHU;
                    default: ;
                endcase
            end
            `IDU_OPC_STORE: begin
                case (funct3)
                    3'b000:  inst_id = idu_pkg::INST_SB;
                    3'b001:  inst_id = idu_pkg::INST_SH;
                    3'b010:  inst_id = idu_pkg::INST_SW;
                    default: ;
                endcase
            end
            `IDU_OPC_BRANCH: begin
                case (funct3)
                    3'b000:  inst_id = idu_pkg::INST_BEQ;
                    3'b001:  inst_id = idu_pkg::INST_BNE;
                    3'b100:  inst_id = idu_pkg::INST_BLT;
                    3'b101:  inst_id = idu_pkg::INST_BGE;
                    3'b110:  inst_id = idu_pkg::INST_BLTU;
                    3'b111:  inst_id = idu_pkg::INST_BGEU;
                    default: ;
                endcase
            end
            `IDU_OPC_JAL:   inst_id = idu_pkg::INST_JAL;
            `IDU_OPC_LUI:   inst_id = idu_pkg::INST_LUI;
            `IDU_OPC_AUIPC: inst_id = idu_pkg::INST_AUIPC;
            `IDU_OPC_JALR: begin
                if (funct3 == 3'b000) inst_id = idu_pkg::INST_JALR;
            end
            `IDU_OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        // Whole I immediate zero for ecall, ebreak has bit 20 set
                        if (inst.i.imm_11_0 == 12'h000) begin
                            inst_id = idu_pkg::INST_ECALL;
                        end else if (f7_mret) begin
                            inst_id = idu_pkg::INST_MRET;
                        end
                    end
                    3'b001:  inst_id = idu_pkg::INST_CSRRW;
                    3'b010:  inst_id = idu_pkg::INST_CSRRS;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== source/idu_pkg.sv ====
`include "idu_defines.svh"

package idu_pkg;

    // One view per instruction format, MSB first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`IDU_REG_W-1:0] rs2;
        logic [`IDU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`IDU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [`IDU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [`IDU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`IDU_REG_W-1:0] rs2;
        logic [`IDU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`IDU_REG_W-1:0] rs2;
        logic [`IDU_REG_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;   // Sits where rd bit 0 would be
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`IDU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [`IDU_REG_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // Same 32 bits, read through whichever format applies
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_word_u;

    typedef enum logic [5:0] {
        INST_ILLEGAL,
        INST_ADD, INST_SUB, INST_SLL, INST_SLT, INST_SLTU,
        INST_XOR, INST_SRL, INST_SRA, INST_OR, INST_AND,
        INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI, INST_ORI,
        INST_ANDI, INST_SLLI, INST_SRLI, INST_SRAI,
        INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU,
        INST_SB, INST_SH, INST_SW,
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        INST_LUI, INST_AUIPC, INST_JAL, INST_JALR,
        INST_CSRRW, INST_CSRRS, INST_ECALL, INST_MRET
    } inst_id_e;

    // Execute unit numbering, 0 also covers addi
    typedef enum logic [5:0] {
        ALU_NONE  = 6'd0,  ALU_AUIPC = 6'd1,  ALU_LUI   = 6'd2,  ALU_JUMP  = 6'd3,
        ALU_BEQ   = 6'd4,  ALU_SW    = 6'd5,  ALU_LW    = 6'd6,  ALU_SLTIU = 6'd7,
        ALU_BNE   = 6'd8,  ALU_ADD   = 6'd9,  ALU_SUB   = 6'd10, ALU_OR    = 6'd11,
        ALU_XOR   = 6'd12, ALU_SLTU  = 6'd13, ALU_BGE   = 6'd14, ALU_SLLI  = 6'd15,
        ALU_ANDI  = 6'd16, ALU_SRLI  = 6'd17, ALU_SLTI  = 6'd18, ALU_BLT   = 6'd19,
        ALU_BLTU  = 6'd20, ALU_BGEU  = 6'd21, ALU_SLL   = 6'd22, ALU_SLT   = 6'd23,
        ALU_XORI  = 6'd24, ALU_ORI   = 6'd25, ALU_LBU   = 6'd26, ALU_SRAI  = 6'd27,
        ALU_SB    = 6'd28, ALU_SH    = 6'd29, ALU_AND   = 6'd30, ALU_LB    = 6'd31,
        ALU_LH    = 6'd32, ALU_SRL   = 6'd33, ALU_SRA   = 6'd34, ALU_LHU   = 6'd35,
        ALU_CSRRW = 6'd36, ALU_CSRRS = 6'd37
    } alu_sel_e;

    typedef enum logic [2:0] {
        PC_SEQ    = 3'd0,
        PC_JALR   = 3'd1,
        PC_JAL    = 3'd2,
        PC_BRANCH = 3'd4,
        PC_TRAP   = 3'd5   // ecall and mret
    } pc_sel_e;

    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_U    = 3'd1,
        IMM_J    = 3'd2,
        IMM_S    = 3'd3,
        IMM_B    = 3'd4,
        IMM_ZERO = 3'd5
    } imm_fmt_e;

    typedef struct packed {
        alu_sel_e              alu_sel;
        pc_sel_e               pc_sel;
        logic                  wen;
        logic                  rs_read;
        logic                  csr_wen;
        logic                  ecall;
        logic [`IDU_REG_W-1:0] rd;
        logic [`IDU_REG_W-1:0] rs1;
        logic [`IDU_REG_W-1:0] rs2;
        logic [`IDU_XLEN-1:0]  imm;
    } dec_bundle_t;

endpackage

// ==== source/idu_defines.svh ====
`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

// Word and immediate width
`define IDU_XLEN 32

// Register index width, x0..x31
`define IDU_REG_W 5

// RV32I major opcodes, inst[6:0]
`define IDU_OPC_OP      7'b0110011  // R-type ALU
`define IDU_OPC_OP_IMM  7'b0010011  // I-type ALU
`define IDU_OPC_LOAD    7'b0000011
`define IDU_OPC_STORE   7'b0100011
`define IDU_OPC_BRANCH  7'b1100011
`define IDU_OPC_JAL     7'b1101111
`define IDU_OPC_JALR    7'b1100111
`define IDU_OPC_LUI     7'b0110111
`define IDU_OPC_AUIPC   7'b0010111
`define IDU_OPC_SYSTEM  7'b1110011  // CSR access and traps

// funct7 patterns, inst[31:25]
`define IDU_F7_BASE     7'b0000000
`define IDU_F7_ALT      7'b0100000  // sub, sra, srai
`define IDU_F7_MRET     7'b0011000

`endif
